//--- rtl/clock_enable.sv
`timescale 1ns/1ps

module clock_enable
    import led_pkg::*;
(
    input  logic clk,
    input  logic nrst,
    output logic clk_enable
);

    logic [$clog2(CLK_DIV)-1:0] count;

    // pulse once per wrap of the divider
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            count      <= '0;
            clk_enable <= 1'b0;
        end else if (count == ($clog2(CLK_DIV))'(CLK_DIV - 1)) begin
            count      <= '0;
            clk_enable <= 1'b1;
        end else begin
            count      <= count + 1'b1;
            clk_enable <= 1'b0;
        end
    end

endmodule

//--- rtl/column_mux.sv
`timescale 1ns/1ps

module column_mux
    import led_pkg::*;
(
    input  logic                   clk,
    input  logic                   nrst,
    input  logic                   column_ready,
    input  logic [COL_W-1:0]       ready_col,
    input  logic                   blanking,
    input  logic                   running,
    output logic [NUM_COLUMNS-1:0] mux_out
);

    logic [COL_W-1:0] shown_col;
    logic             have_col;

    // column on the driver outputs, the controller is already shifting the next
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            shown_col <= '0;
            have_col  <= 1'b0;
        end else if (!running) begin
            have_col <= 1'b0;
        end else if (column_ready) begin
            shown_col <= ready_col;
            have_col  <= 1'b1;
        end
    end

    // dark until a column is latched
    assign mux_out = (running && !blanking && have_col) ?
                     (NUM_COLUMNS'(1) << shown_col) : '0;

endmodule

//--- rtl/column_store.sv
`timescale 1ns/1ps

module column_store
    import led_pkg::*;
(
    input  logic                  clk,
    input  logic                  wr_strobe,
    input  fb_write_t             wr,
    input  logic [COL_W-1:0]      rd_col,
    input  logic [WORD_W-1:0]     rd_word,
    output logic [NUM_CHAINS-1:0] rd_data
);

    localparam int DEPTH = NUM_COLUMNS * NUM_WORDS;

    // one entry per column and word, each bit feeds one chain
    logic [NUM_CHAINS-1:0] mem [DEPTH];

    logic [COL_W+WORD_W-1:0] wr_addr;
    logic [COL_W+WORD_W-1:0] rd_addr;

    // column in the upper bits, word in the lower bits
    assign wr_addr = {wr.col, wr.word};
    assign rd_addr = {rd_col, rd_word};

    // host side, one word per strobe
    always_ff @(posedge clk) begin
        if (wr_strobe) begin
            mem[wr_addr] <= wr.data;
        end
    end

    // controller side, data one clock after the address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

//--- rtl/driver_controller.sv
`timescale 1ns/1ps

module driver_controller
    import led_pkg::*;
(
    input  logic                  clk,
    input  logic                  nrst,
    input  logic                  clk_enable,
    input  logic                  start_strobe,
    input  logic                  stop_strobe,
    output logic [COL_W-1:0]      rd_col,
    output logic [WORD_W-1:0]     rd_word,
    input  logic [NUM_CHAINS-1:0] rd_data,
    output drv_bus_t              drv,
    output logic                  column_ready,
    output logic [COL_W-1:0]      ready_col,
    output logic                  blanking,
    output logic                  running
);

    ctrl_state_t                      state;
    logic [COL_W-1:0]                 col;
    logic [COL_W-1:0]                 next_col;
    logic [WORD_W-1:0]                word_cnt;
    logic [$clog2(BLANK_ENABLES)-1:0] blank_cnt;
    logic                             stop_req;
    logic                             gclk_run;

    assign next_col = (col == COL_W'(NUM_COLUMNS - 1)) ? '0 : col + 1'b1;

    // address of the word that goes onto sin at the next sclk fall
    always_comb begin
        if (state == st_idle) begin
            rd_col  = col;
            rd_word = word_cnt;
        end else begin
            rd_col  = (word_cnt == '0) ? next_col : col;
            rd_word = word_cnt - 1'b1;
        end
    end

    assign column_ready = (state == st_latch) && clk_enable;
    assign ready_col    = col;
    assign blanking     = (state == st_blank);
    assign gclk_run     = (state == st_shift_high) || (state == st_shift_low) ||
                          (state == st_latch);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state     <= st_idle;
            drv       <= '0;
            col       <= '0;
            word_cnt  <= WORD_W'(NUM_WORDS - 1);
            blank_cnt <= '0;
            stop_req  <= 1'b0;
            running   <= 1'b0;
        end else begin
            if (stop_strobe && running) begin
                stop_req <= 1'b1;
            end
            if (clk_enable && gclk_run) begin
                drv.gclk <= ~drv.gclk;
            end
            case (state)
                st_idle: begin
                    // first word is already prefetched, sclk rises on the next enable
                    if (start_strobe && !running) begin
                        running <= 1'b1;
                        drv.sin <= rd_data;
                    end else if (running && clk_enable) begin
                        drv.sclk <= 1'b1;
                        state    <= st_shift_high;
                    end
                end
                st_shift_high: begin
                    if (clk_enable) begin
                        drv.sclk <= 1'b0;
                        drv.sin  <= rd_data;
                        state    <= st_shift_low;
                    end
                end
                st_shift_low: begin
                    if (clk_enable) begin
                        if (word_cnt == '0) begin
                            drv.lat <= 1'b1;
                            state   <= st_latch;
                        end else begin
                            word_cnt <= word_cnt - 1'b1;
                            drv.sclk <= 1'b1;
                            state    <= st_shift_high;
                        end
                    end
                end
                st_latch: begin
                    if (clk_enable) begin
                        drv.lat   <= 1'b0;
                        blank_cnt <= '0;
                        state     <= st_blank;
                    end
                end
                st_blank: begin
                    if (clk_enable) begin
                        if (blank_cnt == ($clog2(BLANK_ENABLES))'(BLANK_ENABLES - 1)) begin
                            word_cnt <= WORD_W'(NUM_WORDS - 1);
                            if (stop_req) begin
                                // back to column 0 for the next start
                                col      <= '0;
                                stop_req <= 1'b0;
                                running  <= 1'b0;
                                drv.sin  <= '0;
                                drv.gclk <= 1'b0;
                                state    <= st_idle;
                            end else begin
                                col      <= next_col;
                                drv.sclk <= 1'b1;
                                state    <= st_shift_high;
                            end
                        end else begin
                            blank_cnt <= blank_cnt + 1'b1;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

//--- rtl/led_panel_top.sv
`timescale 1ns/1ps

module led_panel_top
    import led_pkg::*;
(
    input  logic                   clk,
    input  logic                   nrst,
    input  logic                   wr_strobe,
    input  fb_write_t              wr,
    input  logic                   start_strobe,
    input  logic                   stop_strobe,
    output drv_bus_t               drv,
    output logic [NUM_COLUMNS-1:0] mux_out,
    output logic                   running
);

    logic                  clk_enable;
    logic [COL_W-1:0]      rd_col;
    logic [WORD_W-1:0]     rd_word;
    logic [NUM_CHAINS-1:0] rd_data;
    logic                  column_ready;
    logic [COL_W-1:0]      ready_col;
    logic                  blanking;

    // shared pacing for shift and display
    clock_enable u_clock_enable (
        .clk        (clk),
        .nrst       (nrst),
        .clk_enable (clk_enable)
    );

    column_store u_column_store (
        .clk       (clk),
        .wr_strobe (wr_strobe),
        .wr        (wr),
        .rd_col    (rd_col),
        .rd_word   (rd_word),
        .rd_data   (rd_data)
    );

    driver_controller u_driver_controller (
        .clk          (clk),
        .nrst         (nrst),
        .clk_enable   (clk_enable),
        .start_strobe (start_strobe),
        .stop_strobe  (stop_strobe),
        .rd_col       (rd_col),
        .rd_word      (rd_word),
        .rd_data      (rd_data),
        .drv          (drv),
        .column_ready (column_ready),
        .ready_col    (ready_col),
        .blanking     (blanking),
        .running      (running)
    );

    column_mux u_column_mux (
        .clk          (clk),
        .nrst         (nrst),
        .column_ready (column_ready),
        .ready_col    (ready_col),
        .blanking     (blanking),
        .running      (running),
        .mux_out      (mux_out)
    );

endmodule

//--- rtl/led_pkg.sv
package led_pkg;

    // panel geometry
    localparam int NUM_CHAINS  = 30;
    localparam int NUM_WORDS   = 16;
    localparam int NUM_COLUMNS = 8;

    // index widths
    localparam int COL_W  = 3;
    localparam int WORD_W = 4;

    // clocks per enable pulse
    localparam int CLK_DIV = 4;

    // enable periods the column drivers stay dark after a latch
    localparam int BLANK_ENABLES = 8;

    // controller states, one enable period per step
    typedef enum logic [2:0] {
        st_idle,
        st_shift_high,
        st_shift_low,
        st_latch,
        st_blank
    } ctrl_state_t;

    // one host write into the framebuffer
    typedef struct packed {
        logic [COL_W-1:0]      col;
        logic [WORD_W-1:0]     word;
        logic [NUM_CHAINS-1:0] data;
    } fb_write_t;

    // pins shared by all driver chains, sin has one bit per chain
    typedef struct packed {
        logic                  sclk;
        logic                  lat;
        logic                  gclk;
        logic [NUM_CHAINS-1:0] sin;
    } drv_bus_t;

endpackage

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing \
    --top-module tb_led_panel \
    -f src.f \
    -o tb_led_panel

./obj_dir/tb_led_panel > sim.log 2>&1 || true
cat sim.log

if grep -qF "*** PASSED ***" sim.log; then
    echo "simulation result: pass"
    exit 0
else
    echo "simulation result: fail"
    exit 1
fi

//--- sim/led_panel_trace.txt
# first value: run length in clocks, sets the timeout
# W col word hex_value = write, S = start, P = stop, N count = wait clocks
3000
W 3 7 2aaaaaaa
W 5 0 15555555
W 7 15 3fffffff
W 1 8 00000001
N 8
S
N 1700
P
N 20
# new content for column 0 before the restart
W 0 15 12345678
W 0 14 0abcdef0
W 0 1 3c3c3c3c
W 0 0 00ff00ff
N 8
S
N 700
P
N 20

//--- sim/panel_checker.sv
`timescale 1ns/1ps

module panel_checker
    import led_pkg::*;
(
    input  logic                   clk,
    input  logic                   nrst,
    input  logic                   wr_strobe,
    input  fb_write_t              wr,
    input  logic                   start_strobe,
    input  logic                   stop_strobe,
    input  drv_bus_t               drv,
    input  logic [NUM_COLUMNS-1:0] mux_out,
    input  logic                   running,
    output int                     error_count,
    output int                     check_count,
    output int                     column_count
);

    logic [NUM_CHAINS-1:0] shadow [NUM_COLUMNS][NUM_WORDS];
    drv_bus_t              prev_drv;
    logic [COL_W-1:0]      shift_col;
    logic [COL_W-1:0]      shown_col;
    logic                  stop_pending;
    logic                  idle;
    int                    bit_cnt;
    int                    lat_len;
    int                    blank_pos;

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_count = check_count + 1;
        if (got !== exp) begin
            error_count = error_count + 1;
            $display("error: %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic protocol_fail(input string msg);
        error_count = error_count + 1;
        $display("protocol failure at %0t: %s", $time, msg);
    endtask

    // samples taken at the edge see the values of the previous clock
    always @(posedge clk) begin
        if (!nrst) begin
            error_count  = 0;
            check_count  = 0;
            column_count = 0;
            prev_drv     = '0;
            shift_col    = '0;
            shown_col    = '0;
            stop_pending = 1'b0;
            idle         = 1'b1;
            bit_cnt      = 0;
            lat_len      = 0;
            blank_pos    = 0;
        end else begin
            if (wr_strobe) begin
                shadow[wr.col][wr.word] = wr.data;
            end
            // everything dark from reset or a stop until the next start
            if (idle) begin
                compare("running", 32'(running), 32'd0);
                compare("sclk", 32'(drv.sclk), 32'd0);
                compare("lat", 32'(drv.lat), 32'd0);
                compare("gclk", 32'(drv.gclk), 32'd0);
                compare("sin", 32'(drv.sin), 32'd0);
                compare("mux_out", 32'(mux_out), 32'd0);
            end
            if (start_strobe) begin
                idle = 1'b0;
            end
            // data is checked as sclk rises
            if (drv.sclk && !prev_drv.sclk) begin
                if (bit_cnt < NUM_WORDS) begin
                    compare("sin", 32'(drv.sin),
                            32'(shadow[shift_col][WORD_W'(NUM_WORDS - 1 - bit_cnt)]));
                end else begin
                    protocol_fail("more than 16 sclk rises before a latch");
                end
                bit_cnt = bit_cnt + 1;
            end
            if (drv.lat && !prev_drv.lat) begin
                if (bit_cnt != NUM_WORDS) begin
                    protocol_fail("latch did not follow exactly 16 sclk rises");
                end
                shown_col    = shift_col;
                shift_col    = shift_col + 1'b1;
                bit_cnt      = 0;
                lat_len      = 0;
                column_count = column_count + 1;
            end
            if (drv.lat) begin
                lat_len = lat_len + 1;
                compare("sclk", 32'(drv.sclk), 32'd0);
            end
            if (!drv.lat && prev_drv.lat) begin
                compare("lat_length", 32'(lat_len), 32'(CLK_DIV));
                blank_pos = 1;
            end
            // blanking window, then the latched column goes on
            if (blank_pos >= 1 && blank_pos <= BLANK_ENABLES * CLK_DIV) begin
                compare("mux_out", 32'(mux_out), 32'd0);
                if (blank_pos > 1 && drv.gclk != prev_drv.gclk) begin
                    protocol_fail("gclk toggled during blanking");
                end
                blank_pos = blank_pos + 1;
            end else if (blank_pos > BLANK_ENABLES * CLK_DIV) begin
                if (stop_pending) begin
                    compare("running", 32'(running), 32'd0);
                    compare("mux_out", 32'(mux_out), 32'd0);
                    shift_col    = '0;
                    stop_pending = 1'b0;
                    idle         = 1'b1;
                end else begin
                    compare("mux_out", 32'(mux_out), 32'(NUM_COLUMNS'(1) << shown_col));
                end
                blank_pos = 0;
            end
            if (stop_strobe && running) begin
                stop_pending = 1'b1;
            end
            prev_drv = drv;
        end
    end

endmodule

//--- sim/tb_led_panel.sv
`timescale 1ns/1ps

module tb_led_panel
    import led_pkg::*;
();

    logic                   clk;
    logic                   nrst;
    logic                   wr_strobe;
    fb_write_t              wr;
    logic                   start_strobe;
    logic                   stop_strobe;
    drv_bus_t               drv;
    logic [NUM_COLUMNS-1:0] mux_out;
    logic                   running;
    int                     error_count;
    int                     check_count;
    int                     column_count;
    int                     tb_errors;
    int                     cycle;
    int                     timeout_limit;

    led_panel_top u_dut (
        .clk          (clk),
        .nrst         (nrst),
        .wr_strobe    (wr_strobe),
        .wr           (wr),
        .start_strobe (start_strobe),
        .stop_strobe  (stop_strobe),
        .drv          (drv),
        .mux_out      (mux_out),
        .running      (running)
    );

    panel_checker u_checker (
        .clk          (clk),
        .nrst         (nrst),
        .wr_strobe    (wr_strobe),
        .wr           (wr),
        .start_strobe (start_strobe),
        .stop_strobe  (stop_strobe),
        .drv          (drv),
        .mux_out      (mux_out),
        .running      (running),
        .error_count  (error_count),
        .check_count  (check_count),
        .column_count (column_count)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (timeout_limit > 0 && cycle >= timeout_limit) begin
            $display("timeout: run did not finish within %0d cycles", timeout_limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // pattern mixes every address bit
    function automatic logic [31:0] fill_value(input int addr);
        logic [31:0] a;
        a = 32'(addr);
        return (a * 32'h2f1b_4c63) ^ (a << 17) ^ 32'h0a5c_3e91;
    endfunction

    task automatic write_word(input int c, input int w, input logic [31:0] value);
        @(posedge clk);
        #2;
        wr_strobe = 1'b1;
        wr.col    = COL_W'(c);
        wr.word   = WORD_W'(w);
        wr.data   = NUM_CHAINS'(value);
        @(posedge clk);
        #2;
        wr_strobe = 1'b0;
    endtask

    task automatic start_run();
        @(posedge clk);
        #2;
        start_strobe = 1'b1;
        @(posedge clk);
        #2;
        start_strobe = 1'b0;
        while (!running) begin
            @(posedge clk);
            #2;
        end
    endtask

    // stop lands at the end of blanking
    task automatic stop_run();
        @(posedge clk);
        #2;
        stop_strobe = 1'b1;
        @(posedge clk);
        #2;
        stop_strobe = 1'b0;
        while (running) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic run_trace(input int fd);
        string       line;
        int          got_total;
        int          c;
        int          w;
        int          n;
        logic [31:0] value;
        got_total = 0;
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n == 0 || line.len() == 0 || line.getc(0) == "#" || line.getc(0) == "\n") begin
                continue;
            end
            if (got_total == 0) begin
                n = $sscanf(line, "%d", c);
                timeout_limit = 2 * c + 1000;
                got_total = 1;
            end else if (line.getc(0) == "W") begin
                n = $sscanf(line, "W %d %d %h", c, w, value);
                write_word(c, w, value);
            end else if (line.getc(0) == "S") begin
                start_run();
            end else if (line.getc(0) == "P") begin
                stop_run();
            end else if (line.getc(0) == "N") begin
                n = $sscanf(line, "N %d", c);
                repeat (c) @(posedge clk);
            end else begin
                $display("unknown trace command: %s", line);
                tb_errors = tb_errors + 1;
            end
        end
    endtask

    initial begin
        int fd;
        nrst          = 1'b0;
        wr_strobe     = 1'b0;
        wr            = '0;
        start_strobe  = 1'b0;
        stop_strobe   = 1'b0;
        tb_errors     = 0;
        cycle         = 0;
        timeout_limit = 0;
        fd = $fopen("sim/led_panel_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file sim/led_panel_trace.txt");
            $display("*** FAILED ***");
            $finish;
        end else begin
            repeat (10) @(posedge clk);
            #2;
            nrst = 1'b1;
            // whole framebuffer gets known content first
            for (int a = 0; a < NUM_COLUMNS * NUM_WORDS; a++) begin
                write_word(a / NUM_WORDS, a % NUM_WORDS, fill_value(a));
            end
            run_trace(fd);
            $fclose(fd);
            repeat (4) @(posedge clk);
            if (column_count < 10) begin
                $display("only %0d columns were shifted, at least 10 expected", column_count);
                tb_errors = tb_errors + 1;
            end
            $display("summary: %0d errors, %0d checks, %0d columns",
                     error_count + tb_errors, check_count, column_count);
            if (error_count + tb_errors == 0) begin
                $display("*** PASSED ***");
            end else begin
                $display("*** FAILED ***");
            end
            $finish;
        end
    end

endmodule

//--- src.f
rtl/led_pkg.sv
rtl/clock_enable.sv
rtl/column_store.sv
rtl/driver_controller.sv
rtl/column_mux.sv
rtl/led_panel_top.sv
sim/panel_checker.sv
sim/tb_led_panel.sv
